// ==== Bender.yml ====
package:
  name: mips_core

sources:
  # Package first, then the leaf modules, then the top level
  - source/mips_pkg.sv
  - source/stage_reg.sv
  - source/reg_file.sv
  - source/decode.sv
  - source/alu.sv
  - source/lead_count.sv
  - source/pipe_ctrl.sv
  - source/mips_core.sv

  - target: test
    files:
      - bench/tb_mips_core.sv

// ==== bench/tb_mips_core.sv ====
/*
 * Testbench for the MIPS32 pipeline core
 * Table-driven instruction feed with in-order writeback checking
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    typedef struct {
        string               name;
        mips_pkg::word_t     inst;
        logic                we;
        mips_pkg::reg_addr_t addr;
        mips_pkg::word_t     data;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    mips_pkg::inst_feed_t feed;
    logic                 inst_ready;
    logic                 wb_valid;
    mips_pkg::reg_addr_t  wb_addr;
    mips_pkg::word_t      wb_data;

    row_t   rows[$];
    int     pending[$];
    int     n_expected;
    int     n_seen;
    int     cycles;
    int     limit;
    integer seed;

    mips_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed       (feed),
        .inst_ready (inst_ready),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s: expected data %h, actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input mips_pkg::reg_addr_t exp,
                              input mips_pkg::reg_addr_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s: expected reg %0d, actual %0d", name, exp, act));
    endtask

    function automatic mips_pkg::word_t r_form(input logic [5:0] funct, input int rd,
                                               input int rs, input int rt, input int sa);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), funct};
    endfunction

    function automatic mips_pkg::word_t imm_form(input logic [5:0] op, input int rt,
                                                 input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // SPECIAL2 count, rt repeats rd
    function automatic mips_pkg::word_t count_form(input logic [5:0] funct, input int rd,
                                                   input int rs);
        return {6'h1c, 5'(rs), 5'(rd), 5'(rd), 5'd0, funct};
    endfunction

    task automatic add_row(input string name, input mips_pkg::word_t inst, input int we,
                           input int addr, input mips_pkg::word_t data);
        row_t r;
        r.name = name;
        r.inst = inst;
        r.we   = (we != 0);
        r.addr = 5'(addr);
        r.data = data;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Immediate forms
        add_row("ori", imm_form(6'h0d, 1, 0, 16'h8a5c), 1, 1, 32'h0000_8a5c);
        add_row("andi", imm_form(6'h0c, 2, 1, 16'hf00f), 1, 2, 32'h0000_800c);
        add_row("xori", imm_form(6'h0e, 3, 1, 16'hffff), 1, 3, 32'h0000_75a3);
        add_row("addiu_neg", imm_form(6'h09, 4, 0, 16'hfff0), 1, 4, 32'hffff_fff0);
        add_row("addiu_fwd", imm_form(6'h09, 5, 4, 16'h0020), 1, 5, 32'h0000_0010);
        add_row("slti_true", imm_form(6'h0a, 6, 4, 16'h0001), 1, 6, 32'd1);
        add_row("slti_false", imm_form(6'h0a, 7, 5, 16'hfffe), 1, 7, 32'd0);
        add_row("sltiu", imm_form(6'h0b, 8, 5, 16'hffff), 1, 8, 32'd1);
        add_row("lui", imm_form(6'h0f, 10, 0, 16'h8765), 1, 10, 32'h8765_0000);
        add_row("addi", imm_form(6'h08, 11, 10, 16'h4321), 1, 11, 32'h8765_4321);
        // R-type arithmetic, logic and shifts
        add_row("addu", r_form(6'h21, 12, 10, 11, 0), 1, 12, 32'h0eca_4321);
        add_row("add", r_form(6'h20, 13, 12, 1, 0), 1, 13, 32'h0eca_cd7d);
        add_row("sub", r_form(6'h22, 14, 5, 4, 0), 1, 14, 32'h0000_0020);
        add_row("subu", r_form(6'h23, 15, 0, 14, 0), 1, 15, 32'hffff_ffe0);
        add_row("and", r_form(6'h24, 16, 11, 3, 0), 1, 16, 32'h0000_4121);
        add_row("or", r_form(6'h25, 17, 16, 2, 0), 1, 17, 32'h0000_c12d);
        add_row("xor", r_form(6'h26, 18, 17, 11, 0), 1, 18, 32'h8765_820c);
        add_row("nor", r_form(6'h27, 19, 18, 0, 0), 1, 19, 32'h789a_7df3);
        add_row("slt", r_form(6'h2a, 20, 15, 5, 0), 1, 20, 32'd1);
        add_row("sltu", r_form(6'h2b, 21, 15, 5, 0), 1, 21, 32'd0);
        add_row("sll", r_form(6'h00, 22, 0, 11, 4), 1, 22, 32'h7654_3210);
        add_row("srl", r_form(6'h02, 23, 0, 22, 8), 1, 23, 32'h0076_5432);
        add_row("sra", r_form(6'h03, 24, 0, 11, 12), 1, 24, 32'hfff8_7654);
        add_row("sllv", r_form(6'h04, 25, 5, 11, 0), 1, 25, 32'h4321_0000);
        add_row("srav", r_form(6'h07, 27, 20, 11, 0), 1, 27, 32'hc3b2_a190);
        add_row("chain0", imm_form(6'h09, 28, 0, 16'h0003), 1, 28, 32'd3);
        add_row("chain1", r_form(6'h21, 28, 28, 28, 0), 1, 28, 32'd6);
        add_row("chain2", r_form(6'h21, 29, 28, 28, 0), 1, 29, 32'd12);
        add_row("chain3", r_form(6'h23, 30, 29, 28, 0), 1, 30, 32'd6);
        // Leading-bit counts and their consumers
        add_row("clz_32", count_form(6'h20, 1, 0), 1, 1, 32'd32);
        add_row("clz_0", count_form(6'h20, 2, 10), 1, 2, 32'd0);
        add_row("lui_4000", imm_form(6'h0f, 3, 0, 16'h4000), 1, 3, 32'h4000_0000);
        add_row("clz_1", count_form(6'h20, 4, 3), 1, 4, 32'd1);
        add_row("clz_16", count_form(6'h20, 5, 17), 1, 5, 32'd16);
        add_row("clz_use", r_form(6'h21, 6, 5, 5, 0), 1, 6, 32'd32);
        add_row("clo_0", count_form(6'h21, 7, 1), 1, 7, 32'd0);
        add_row("clo_1", count_form(6'h21, 8, 10), 1, 8, 32'd1);
        add_row("lui_ffff", imm_form(6'h0f, 9, 0, 16'hffff), 1, 9, 32'hffff_0000);
        add_row("clo_16", count_form(6'h21, 12, 9), 1, 12, 32'd16);
        add_row("all_ones", r_form(6'h27, 13, 0, 0, 0), 1, 13, 32'hffff_ffff);
        add_row("clo_32", count_form(6'h21, 14, 13), 1, 14, 32'd32);
        add_row("clz_of_clo", count_form(6'h20, 15, 14), 1, 15, 32'd26);
        add_row("count_sum", r_form(6'h21, 16, 15, 14, 0), 1, 16, 32'h0000_003a);
        // HI/LO moves
        add_row("mthi", r_form(6'h11, 0, 11, 0, 0), 0, 0, 32'd0);
        add_row("mfhi", r_form(6'h10, 17, 0, 0, 0), 1, 17, 32'h8765_4321);
        add_row("mtlo", r_form(6'h13, 0, 16, 0, 0), 0, 0, 32'd0);
        add_row("mflo", r_form(6'h12, 18, 0, 0, 0), 1, 18, 32'h0000_003a);
        add_row("mthi_fwd", r_form(6'h11, 0, 18, 0, 0), 0, 0, 32'd0);
        add_row("mtlo_2", r_form(6'h13, 0, 3, 0, 0), 0, 0, 32'd0);
        add_row("mfhi_2", r_form(6'h10, 19, 0, 0, 0), 1, 19, 32'h0000_003a);
        add_row("mflo_2", r_form(6'h12, 20, 0, 0, 0), 1, 20, 32'h4000_0000);
        // Conditional moves, $0 targets and no-op encodings
        add_row("movz_taken", r_form(6'h0a, 21, 11, 0, 0), 1, 21, 32'h8765_4321);
        add_row("movz_skip", r_form(6'h0a, 22, 11, 3, 0), 0, 0, 32'd0);
        add_row("movn_taken", r_form(6'h0b, 23, 19, 3, 0), 1, 23, 32'h0000_003a);
        add_row("movn_skip", r_form(6'h0b, 24, 19, 0, 0), 0, 0, 32'd0);
        add_row("after_movs", r_form(6'h21, 25, 22, 24, 0), 1, 25, 32'h764c_a864);
        add_row("write_r0_i", imm_form(6'h09, 0, 11, 16'h0005), 0, 0, 32'd0);
        add_row("write_r0_r", r_form(6'h21, 0, 11, 11, 0), 0, 0, 32'd0);
        add_row("read_r0", r_form(6'h21, 26, 0, 0, 0), 1, 26, 32'd0);
        add_row("sync", 32'h0000_000f, 0, 0, 32'd0);
        add_row("pref", imm_form(6'h33, 0, 1, 16'h0010), 0, 0, 32'd0);
        add_row("undef_op", 32'hfc00_0000, 0, 0, 32'd0);
        add_row("undef_funct", r_form(6'h01, 27, 11, 11, 0), 0, 0, 32'd0);
        add_row("after_nops", r_form(6'h21, 27, 23, 21, 0), 1, 27, 32'h8765_435b);
    endtask

    // Each reported write belongs to the next row that expects one
    always @(negedge clk) begin : wb_monitor
        int idx;
        if (rst_n && wb_valid) begin
            if (pending.size() == 0) begin
                abort_run($sformatf("Writeback to register %0d after the last expected one",
                                    wb_addr));
            end else begin
                idx = pending.pop_front();
                check_addr(rows[idx].name, rows[idx].addr, wb_addr);
                check_word(rows[idx].name, rows[idx].data, wb_data);
                n_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit)
            abort_run($sformatf("Timeout after %0d cycles, %0d writebacks still missing",
                                cycles, n_expected - n_seen));
    end

    initial begin
        int gap;
        seed   = 9;
        cycles = 0;
        n_seen = 0;
        limit  = 0;
        rst_n  = 1'b0;
        feed   = '0;
        build_table();
        foreach (rows[i])
            if (rows[i].we)
                pending.push_back(i);
        n_expected = pending.size();
        limit      = 40 * rows.size() + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            gap = $unsigned($random(seed)) % 3;
            if (gap > 0) begin
                feed.valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            feed.inst  = rows[i].inst;
            feed.valid = 1'b1;
            // Held until a rising edge sees ready
            while (!inst_ready)
                @(negedge clk);
            @(negedge clk);
        end
        feed.valid = 1'b0;
        while (n_seen < n_expected)
            @(negedge clk);
        // Room for a stray late write to show up
        repeat (10) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/mips_pkg.sv
source/stage_reg.sv
source/reg_file.sv
source/decode.sv
source/alu.sv
source/lead_count.sv
source/pipe_ctrl.sv
source/mips_core.sv
bench/tb_mips_core.sv

// ==== source/alu.sv ====
/*
 * Execute stage ALU
 * Arithmetic, logic, shifts, compares, moves, HI/LO and leading-bit launch
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic             clk,
    input  logic             rst_n,
    input  mips_pkg::id_ex_t in_op,
    input  logic             advance,
    output mips_pkg::word_t  result,
    output logic             cnt_start,
    output logic             cnt_ones,
    output mips_pkg::word_t  cnt_src
);

    mips_pkg::word_t hi;
    mips_pkg::word_t lo;
    mips_pkg::word_t a;
    mips_pkg::word_t b;

    assign a = in_op.opr1;
    assign b = in_op.opr2;

    always_comb begin
        case (in_op.aluop)
            mips_pkg::ALU_ADD, mips_pkg::ALU_ADDU: result = a + b;
            mips_pkg::ALU_SUB, mips_pkg::ALU_SUBU: result = a - b;
            mips_pkg::ALU_AND:  result = a & b;
            mips_pkg::ALU_OR:   result = a | b;
            mips_pkg::ALU_XOR:  result = a ^ b;
            mips_pkg::ALU_NOR:  result = ~(a | b);
            mips_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLTU: result = {31'd0, a < b};
            // Shift amount in opr1, value in opr2
            mips_pkg::ALU_SLL:  result = b << a[4:0];
            mips_pkg::ALU_SRL:  result = b >> a[4:0];
            mips_pkg::ALU_SRA:  result = $signed(b) >>> a[4:0];
            mips_pkg::ALU_MOV:  result = a;
            mips_pkg::ALU_MFHI: result = hi;
            mips_pkg::ALU_MFLO: result = lo;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (advance) begin
            if (in_op.aluop == mips_pkg::ALU_MTHI)
                hi <= a;
            if (in_op.aluop == mips_pkg::ALU_MTLO)
                lo <= a;
        end
    end

    assign cnt_ones  = (in_op.aluop == mips_pkg::ALU_CLO);
    assign cnt_start = advance && (cnt_ones || in_op.aluop == mips_pkg::ALU_CLZ);
    assign cnt_src   = a;

endmodule

`default_nettype wire

// ==== source/decode.sv ====
/*
 * Instruction decode
 * Operation select, immediate extension, operand forwarding and stall request
 */
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  mips_pkg::word_t     inst,
    output logic                r1read,
    output logic                r2read,
    output mips_pkg::reg_addr_t r1addr,
    output mips_pkg::reg_addr_t r2addr,
    input  mips_pkg::word_t     r1data,
    input  mips_pkg::word_t     r2data,
    input  mips_pkg::fwd_t      ex_fwd,
    input  mips_pkg::fwd_t      mem_fwd,
    output mips_pkg::id_ex_t    id_out,
    output logic                stallreq
);

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] funct;

    mips_pkg::alu_op_e   aluop;
    mips_pkg::reg_addr_t wraddr;
    mips_pkg::word_t     ext_imme;
    mips_pkg::word_t     opr1;
    mips_pkg::word_t     opr2;
    logic                legal;
    logic                wreg;
    logic                is_mov;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = inst[5:0];
    assign r1addr = rs;
    assign r2addr = rt;

    // $0 never matches, nothing is forwarded for it
    function automatic logic hit(mips_pkg::fwd_t f, mips_pkg::reg_addr_t a);
        return f.wreg && (f.wraddr == a) && (a != '0);
    endfunction

    always_comb begin
        aluop    = mips_pkg::ALU_NOP;
        legal    = 1'b0;
        r1read   = 1'b0;
        r2read   = 1'b0;
        wreg     = 1'b0;
        is_mov   = 1'b0;
        wraddr   = rt;
        ext_imme = '0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                legal  = (sa == 5'd0);
                r1read = 1'b1;
                r2read = 1'b1;
                wreg   = 1'b1;
                wraddr = rd;
                case (funct)
                    mips_pkg::SP_SLL, mips_pkg::SP_SLLV:  aluop = mips_pkg::ALU_SLL;
                    mips_pkg::SP_SRL, mips_pkg::SP_SRLV:  aluop = mips_pkg::ALU_SRL;
                    mips_pkg::SP_SRA, mips_pkg::SP_SRAV:  aluop = mips_pkg::ALU_SRA;
                    mips_pkg::SP_MOVZ, mips_pkg::SP_MOVN: aluop = mips_pkg::ALU_MOV;
                    mips_pkg::SP_MFHI: aluop = mips_pkg::ALU_MFHI;
                    mips_pkg::SP_MTHI: aluop = mips_pkg::ALU_MTHI;
                    mips_pkg::SP_MFLO: aluop = mips_pkg::ALU_MFLO;
                    mips_pkg::SP_MTLO: aluop = mips_pkg::ALU_MTLO;
                    mips_pkg::SP_ADD:  aluop = mips_pkg::ALU_ADD;
                    mips_pkg::SP_ADDU: aluop = mips_pkg::ALU_ADDU;
                    mips_pkg::SP_SUB:  aluop = mips_pkg::ALU_SUB;
                    mips_pkg::SP_SUBU: aluop = mips_pkg::ALU_SUBU;
                    mips_pkg::SP_AND:  aluop = mips_pkg::ALU_AND;
                    mips_pkg::SP_OR:   aluop = mips_pkg::ALU_OR;
                    mips_pkg::SP_XOR:  aluop = mips_pkg::ALU_XOR;
                    mips_pkg::SP_NOR:  aluop = mips_pkg::ALU_NOR;
                    mips_pkg::SP_SLT:  aluop = mips_pkg::ALU_SLT;
                    mips_pkg::SP_SLTU: aluop = mips_pkg::ALU_SLTU;
                    mips_pkg::SP_SYNC: aluop = mips_pkg::ALU_NOP;
                    default:           legal = 1'b0;
                endcase
                // Forms that differ from rd = rs op rt
                case (funct)
                    mips_pkg::SP_SLL, mips_pkg::SP_SRL, mips_pkg::SP_SRA: begin
                        legal    = (rs == 5'd0);
                        r1read   = 1'b0;
                        ext_imme = {27'd0, sa};
                    end
                    mips_pkg::SP_MFHI, mips_pkg::SP_MFLO: begin
                        legal  = legal && (inst[25:16] == '0);
                        r1read = 1'b0;
                        r2read = 1'b0;
                    end
                    mips_pkg::SP_MTHI, mips_pkg::SP_MTLO: begin
                        legal  = (inst[20:6] == '0);
                        r2read = 1'b0;
                        wreg   = 1'b0;
                    end
                    mips_pkg::SP_SYNC: begin
                        legal  = (inst[25:11] == '0);
                        r1read = 1'b0;
                        r2read = 1'b0;
                        wreg   = 1'b0;
                    end
                    mips_pkg::SP_MOVZ, mips_pkg::SP_MOVN: is_mov = 1'b1;
                    default: ;
                endcase
            end
            mips_pkg::OP_SPECIAL2: begin
                legal  = (sa == 5'd0) &&
                         (funct == mips_pkg::SP2_CLZ || funct == mips_pkg::SP2_CLO);
                aluop  = funct[0] ? mips_pkg::ALU_CLO : mips_pkg::ALU_CLZ;
                r1read = 1'b1;
                wreg   = 1'b1;
                wraddr = rd;
            end
            mips_pkg::OP_ADDI:  aluop = mips_pkg::ALU_ADD;
            mips_pkg::OP_ADDIU: aluop = mips_pkg::ALU_ADDU;
            mips_pkg::OP_SLTI:  aluop = mips_pkg::ALU_SLT;
            mips_pkg::OP_SLTIU: aluop = mips_pkg::ALU_SLTU;
            mips_pkg::OP_ANDI:  aluop = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:   aluop = mips_pkg::ALU_OR;
            mips_pkg::OP_XORI:  aluop = mips_pkg::ALU_XOR;
            mips_pkg::OP_LUI:   aluop = mips_pkg::ALU_OR;
            mips_pkg::OP_PREF:  legal = 1'b1;
            default: ;
        endcase
        // Opcodes 08..0f, logic ops zero-extend, LUI is $0 | imm << 16
        if (opcode[5:3] == 3'b001) begin
            legal  = (opcode != mips_pkg::OP_LUI) || (rs == 5'd0);
            r1read = 1'b1;
            wreg   = 1'b1;
            if (opcode == mips_pkg::OP_LUI)
                ext_imme = {inst[15:0], 16'd0};
            else if (opcode[2])
                ext_imme = {16'd0, inst[15:0]};
            else
                ext_imme = {{16{inst[15]}}, inst[15:0]};
        end
    end

    // Youngest producer wins
    always_comb begin
        if (!r1read)
            opr1 = ext_imme;
        else if (hit(ex_fwd, r1addr))
            opr1 = ex_fwd.data;
        else if (hit(mem_fwd, r1addr))
            opr1 = mem_fwd.data;
        else
            opr1 = r1data;

        if (!r2read)
            opr2 = ext_imme;
        else if (hit(ex_fwd, r2addr))
            opr2 = ex_fwd.data;
        else if (hit(mem_fwd, r2addr))
            opr2 = mem_fwd.data;
        else
            opr2 = r2data;
    end

    // MOVN has funct bit 0 set
    always_comb begin
        id_out.aluop  = legal ? aluop : mips_pkg::ALU_NOP;
        id_out.opr1   = opr1;
        id_out.opr2   = opr2;
        id_out.wraddr = wraddr;
        id_out.wreg   = legal && (is_mov ? ((opr2 == '0) != funct[0]) : wreg);
    end

    assign stallreq = (ex_fwd.nrdy && ((r1read && hit(ex_fwd, r1addr)) ||
                                       (r2read && hit(ex_fwd, r2addr)))) ||
                      (mem_fwd.nrdy && ((r1read && hit(mem_fwd, r1addr)) ||
                                        (r2read && hit(mem_fwd, r2addr))));

endmodule

`default_nettype wire

// ==== source/lead_count.sv ====
/*
 * Leading zero / one counter
 * One bit per cycle, stops at the first opposite bit or after 32
 */
`timescale 1ns/1ps
`default_nettype none

module lead_count (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            ones,
    input  mips_pkg::word_t src,
    output logic            done,
    output mips_pkg::word_t count
);

    mips_pkg::word_t sh;
    logic [5:0]      cnt;
    logic            pol;

    // Top bit is judged at start, so counts of 0 and 1 finish right away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh   <= '0;
            cnt  <= '0;
            pol  <= 1'b0;
            done <= 1'b1;
        end else if (start) begin
            sh   <= src << 1;
            cnt  <= {5'd0, src[31] == ones};
            pol  <= ones;
            done <= (src[31] != ones) || (src[30] != ones);
        end else if (!done) begin
            sh   <= sh << 1;
            cnt  <= cnt + 6'd1;
            done <= (sh[30] != pol) || (cnt == 6'd31);
        end
    end

    assign count = {26'd0, cnt};

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
/*
 * MIPS32 integer pipeline, ID / EX / MEM / WB
 * Instruction feed in, register writes reported on the writeback port
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::inst_feed_t feed,
    output logic                 inst_ready,
    output logic                 wb_valid,
    output mips_pkg::reg_addr_t  wb_addr,
    output mips_pkg::word_t      wb_data
);

    mips_pkg::inst_feed_t if_q;
    mips_pkg::id_ex_t     id_d;
    mips_pkg::id_ex_t     ex_q;
    mips_pkg::ex_mem_t    ex_d;
    mips_pkg::ex_mem_t    mem_q;
    mips_pkg::mem_wb_t    mem_d;
    mips_pkg::mem_wb_t    wb_q;
    mips_pkg::fwd_t       ex_fwd;
    mips_pkg::fwd_t       mem_fwd;

    mips_pkg::reg_addr_t r1addr;
    mips_pkg::reg_addr_t r2addr;
    mips_pkg::word_t     r1data;
    mips_pkg::word_t     r2data;
    mips_pkg::word_t     alu_res;
    mips_pkg::word_t     cnt_src;
    mips_pkg::word_t     cnt_val;
    logic                r1read;
    logic                r2read;
    logic                stallreq;
    logic                cnt_start;
    logic                cnt_ones;
    logic                cnt_done;
    logic                ex_is_cnt;
    logic                if_en;
    logic                id_en;
    logic                ex_en;
    logic                mem_en;
    logic                ex_bubble;
    logic                wb_bubble;

    stage_reg #(.T(mips_pkg::inst_feed_t)) u_if_id (
        .clk(clk), .rst_n(rst_n), .en(if_en), .bubble(1'b0), .d(feed), .q(if_q)
    );

    decode u_decode (
        .inst     (if_q.valid ? if_q.inst : '0),
        .r1read   (r1read),
        .r2read   (r2read),
        .r1addr   (r1addr),
        .r2addr   (r2addr),
        .r1data   (r1data),
        .r2data   (r2data),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .id_out   (id_d),
        .stallreq (stallreq)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .r1addr (r1read ? r1addr : '0),
        .r2addr (r2read ? r2addr : '0),
        .r1data (r1data),
        .r2data (r2data),
        .we     (wb_valid),
        .waddr  (wb_q.wraddr),
        .wdata  (wb_q.data)
    );

    stage_reg #(.T(mips_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .en(id_en), .bubble(ex_bubble), .d(id_d), .q(ex_q)
    );

    alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_op     (ex_q),
        .advance   (ex_en),
        .result    (alu_res),
        .cnt_start (cnt_start),
        .cnt_ones  (cnt_ones),
        .cnt_src   (cnt_src)
    );

    assign ex_is_cnt = (ex_q.aluop == mips_pkg::ALU_CLZ) || (ex_q.aluop == mips_pkg::ALU_CLO);
    assign ex_d      = '{wreg: ex_q.wreg, wraddr: ex_q.wraddr, result: alu_res,
                         cnt_pend: ex_is_cnt};
    assign ex_fwd    = '{wreg: ex_q.wreg, wraddr: ex_q.wraddr, data: alu_res,
                         nrdy: ex_is_cnt};

    stage_reg #(.T(mips_pkg::ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n), .en(ex_en), .bubble(1'b0), .d(ex_d), .q(mem_q)
    );

    lead_count u_lead_count (
        .clk   (clk),
        .rst_n (rst_n),
        .start (cnt_start),
        .ones  (cnt_ones),
        .src   (cnt_src),
        .done  (cnt_done),
        .count (cnt_val)
    );

    // Count replaces the ALU result once the counter is done
    assign mem_d   = '{wreg: mem_q.wreg, wraddr: mem_q.wraddr,
                       data: mem_q.cnt_pend ? cnt_val : mem_q.result};
    assign mem_fwd = '{wreg: mem_q.wreg, wraddr: mem_q.wraddr, data: mem_d.data,
                       nrdy: mem_q.cnt_pend && !cnt_done};

    stage_reg #(.T(mips_pkg::mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .en(mem_en), .bubble(wb_bubble), .d(mem_d), .q(wb_q)
    );

    pipe_ctrl u_pipe_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .stallreq   (stallreq),
        .mem_wait   (mem_fwd.nrdy),
        .inst_ready (inst_ready),
        .if_en      (if_en),
        .id_en      (id_en),
        .ex_en      (ex_en),
        .mem_en     (mem_en),
        .ex_bubble  (ex_bubble),
        .wb_bubble  (wb_bubble)
    );

    assign wb_valid = wb_q.wreg && (wb_q.wraddr != '0);
    assign wb_addr  = wb_q.wraddr;
    assign wb_data  = wb_q.data;

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
/*
 * MIPS32 core shared types
 * Words, register numbers, ALU operations, encoding fields and stage payloads
 */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // NOP must stay at zero, a cleared payload decodes as a bubble
    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MOV, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO, ALU_CLZ, ALU_CLO
    } alu_op_e;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_PREF     = 6'h33;

    // SPECIAL funct
    localparam logic [5:0] SP_SLL  = 6'h00;
    localparam logic [5:0] SP_SRL  = 6'h02;
    localparam logic [5:0] SP_SRA  = 6'h03;
    localparam logic [5:0] SP_SLLV = 6'h04;
    localparam logic [5:0] SP_SRLV = 6'h06;
    localparam logic [5:0] SP_SRAV = 6'h07;
    localparam logic [5:0] SP_MOVZ = 6'h0a;
    localparam logic [5:0] SP_MOVN = 6'h0b;
    localparam logic [5:0] SP_SYNC = 6'h0f;
    localparam logic [5:0] SP_MFHI = 6'h10;
    localparam logic [5:0] SP_MTHI = 6'h11;
    localparam logic [5:0] SP_MFLO = 6'h12;
    localparam logic [5:0] SP_MTLO = 6'h13;
    localparam logic [5:0] SP_ADD  = 6'h20;
    localparam logic [5:0] SP_ADDU = 6'h21;
    localparam logic [5:0] SP_SUB  = 6'h22;
    localparam logic [5:0] SP_SUBU = 6'h23;
    localparam logic [5:0] SP_AND  = 6'h24;
    localparam logic [5:0] SP_OR   = 6'h25;
    localparam logic [5:0] SP_XOR  = 6'h26;
    localparam logic [5:0] SP_NOR  = 6'h27;
    localparam logic [5:0] SP_SLT  = 6'h2a;
    localparam logic [5:0] SP_SLTU = 6'h2b;

    // SPECIAL2 funct
    localparam logic [5:0] SP2_CLZ = 6'h20;
    localparam logic [5:0] SP2_CLO = 6'h21;

    // All-zero value of each payload is an invalid, non-writing entry
    typedef struct packed {
        alu_op_e   aluop;
        word_t     opr1;
        word_t     opr2;
        logic      wreg;
        reg_addr_t wraddr;
    } id_ex_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wraddr;
        word_t     result;
        logic      cnt_pend;
    } ex_mem_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wraddr;
        word_t     data;
    } mem_wb_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wraddr;
        word_t     data;
        logic      nrdy;
    } fwd_t;

    typedef struct packed {
        word_t inst;
        logic  valid;
    } inst_feed_t;

endpackage

`default_nettype wire

// ==== source/pipe_ctrl.sv ====
/*
 * Pipeline controller
 * Turns dependency stalls and counter waits into stage enables and bubbles
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic stallreq,
    input  logic mem_wait,
    output logic inst_ready,
    output logic if_en,
    output logic id_en,
    output logic ex_en,
    output logic mem_en,
    output logic ex_bubble,
    output logic wb_bubble
);

    typedef enum logic [1:0] {RUN, DEP_STALL, CNT_WAIT} state_e;

    state_e state_nxt;

    // Counter wait outranks a decode stall
    always_comb begin
        if (mem_wait)
            state_nxt = CNT_WAIT;
        else if (stallreq)
            state_nxt = DEP_STALL;
        else
            state_nxt = RUN;
    end

    assign if_en      = (state_nxt == RUN);
    assign id_en      = (state_nxt != CNT_WAIT);
    assign ex_en      = id_en;
    assign mem_en     = id_en;
    assign ex_bubble  = (state_nxt == DEP_STALL);
    assign wb_bubble  = (state_nxt == CNT_WAIT);
    assign inst_ready = if_en;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
/*
 * General purpose register file
 * 32 x 32, two read ports with write-through, $0 reads zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t r1addr,
    input  mips_pkg::reg_addr_t r2addr,
    output mips_pkg::word_t     r1data,
    output mips_pkg::word_t     r2data,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign r1data = (r1addr == '0) ? '0 :
                    (we && waddr == r1addr) ? wdata : regs[r1addr];
    assign r2data = (r2addr == '0) ? '0 :
                    (we && waddr == r2addr) ? wdata : regs[r2addr];

endmodule

`default_nettype wire

// ==== source/stage_reg.sv ====
/*
 * Pipeline stage register for any payload, with hold and bubble insert
 */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic bubble,
    input  T     d,
    output T     q
);

    // Zero payload is a non-writing bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else if (bubble)
            q <= '0;
        else if (en)
            q <= d;
    end

endmodule

`default_nettype wire
